//--- include/routerArb_config.svh
`ifndef ROUTER_ARB_CONFIG_SVH
`define ROUTER_ARB_CONFIG_SVH

// ====================
// Router geometry
// ====================

// Local, North, East, West, South
`define NUM_PORTS 5

// Flit layout
`define FLIT_W 16
`define LEN_W 12  // Packet length, also the hold time in cycles
`define ID_W 3    // Flit id, top bits of every flit

`endif

//--- verilog/routerArbPkg.sv
`include "routerArb_config.svh"

package routerArbPkg;

  // ====================
  // Flit kinds
  // ====================

  typedef enum logic [`ID_W-1:0] {
    flitIdle = 0,
    flitHead = 1,  // Carries the packet length
    flitBody = 2,
    flitTail = 3
  } flitKind;

  // ====================
  // Flit word
  // ====================

  typedef struct packed {
    logic [`ID_W-1:0] id;
    logic             spare;
    logic [`LEN_W-1:0] len;
  } headView;

  typedef struct packed {
    logic [`ID_W-1:0]        id;
    logic [`FLIT_W-`ID_W-1:0] payload;
  } bodyView;

  // Same 16 bits, read as header or as payload
  typedef union packed {
    headView head;
    bodyView body;
  } flitWord;

  typedef logic [$clog2(`NUM_PORTS)-1:0] portIdx;

endpackage

//--- verilog/portLink.sv
interface portLink;
  import routerArbPkg::*;

  logic    req;        // Header through tail
  logic    timesUp;    // Hold time spent
  logic    flitValid;
  flitWord flit;
  logic    runTimer;   // Owner keeps the grant

  // Port unit side
  modport unit (
    output req,
    output timesUp,
    output flitValid,
    output flit,
    input  runTimer
  );

  // Arbiter side
  modport arb (
    input  req,
    input  timesUp,
    input  flitValid,
    input  flit,
    output runTimer
  );

endinterface

//--- verilog/flitDecoder.sv
`include "routerArb_config.svh"

module flitDecoder (
  input  logic                                 clk,
  input  logic                                 rst,
  input  logic [`NUM_PORTS-1:0]                inValid,
  input  logic [`NUM_PORTS-1:0][`FLIT_W-1:0]   inFlit,
  output logic [`NUM_PORTS-1:0]                decValid,
  output routerArbPkg::flitWord [`NUM_PORTS-1:0] decFlit,
  output routerArbPkg::flitKind [`NUM_PORTS-1:0] decKind,
  output logic [`NUM_PORTS-1:0][`LEN_W-1:0]    decLen
);
  import routerArbPkg::*;

  // ====================
  // Input stage
  // ====================

  always_ff @(posedge clk)
  begin
    if (rst)
      decValid <= '0;
    else
      decValid <= inValid;
  end

  always_ff @(posedge clk)
  begin
    for (int p = 0; p < `NUM_PORTS; p++)
      decFlit[p] <= inFlit[p];
  end

  // ====================
  // Decode
  // ====================

  always_comb
  begin
    for (int p = 0; p < `NUM_PORTS; p++)
    begin
      decKind[p] = flitIdle;
      if (decValid[p])
      begin
        case (decFlit[p].body.id)
          flitHead: decKind[p] = flitHead;
          flitBody: decKind[p] = flitBody;
          flitTail: decKind[p] = flitTail;
          default:  decKind[p] = flitIdle;  // Unknown id
        endcase
      end
      decLen[p] = decFlit[p].head.len;  // Only meaningful on a header
    end
  end

  for (genvar p = 0; p < `NUM_PORTS; p++)
  begin : gIdCheck
    // A strobed input flit must carry a known id when it is decoded
    assert property (@(posedge clk) disable iff (rst)
      inValid[p] |=> decFlit[p].head.id inside {flitHead, flitBody, flitTail})
      else $error("port %0d: valid flit with unknown id", p);
  end

endmodule

//--- verilog/portTimer.sv
`include "routerArb_config.svh"

module portTimer (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  decValid,
  input  routerArbPkg::flitWord decFlit,
  input  routerArbPkg::flitKind decKind,
  input  logic [`LEN_W-1:0]     decLen,
  portLink.unit                 link
);
  import routerArbPkg::*;

  logic              reqFlag;
  logic [`LEN_W-1:0] lenReg;
  logic [`LEN_W-1:0] count;

  // ====================
  // Request tracking
  // ====================

  always_ff @(posedge clk)
  begin
    if (rst)
      reqFlag <= 1'b0;
    else if (decKind == flitHead)
      reqFlag <= 1'b1;
    else if (decKind == flitTail)
      reqFlag <= 1'b0;  // Drops after the tail cycle
  end

  // Header raises the request in its own cycle
  assign link.req = reqFlag || (decKind == flitHead);

  assign link.flitValid = decValid;
  assign link.flit      = decFlit;

  // ====================
  // Hold timer
  // ====================

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      lenReg <= '0;
      count  <= '0;
    end
    else
    begin
      if (decKind == flitHead)
        lenReg <= decLen;
      if (link.runTimer)
        count <= count + 1'b1;
      else
        count <= '0;  // Fresh count on every new grant
    end
  end

  assign link.timesUp = (count == lenReg);

  // The arbiter must stop the timer before the count runs past the length
  assert property (@(posedge clk) disable iff (rst)
    link.runTimer |-> count <= lenReg)
    else $error("hold counter passed the latched length");

endmodule

//--- verilog/switchArbiter.sv
`include "routerArb_config.svh"

module switchArbiter (
  input  logic                 clk,
  input  logic                 rst,
  portLink.arb                 links [`NUM_PORTS],
  output logic [`NUM_PORTS:0]  grantState,
  output logic                 outValid,
  output logic [`FLIT_W-1:0]   outFlit
);
  import routerArbPkg::*;

  logic [`NUM_PORTS-1:0]          req;
  logic [`NUM_PORTS-1:0]          timesUp;
  logic [`NUM_PORTS-1:0]          flitValid;
  flitWord [`NUM_PORTS-1:0]       flit;
  logic [`NUM_PORTS-1:0]          runTimer;
  logic [`NUM_PORTS:0]            nextState;
  portIdx                         owner;

  // Interface arrays need constant indices
  for (genvar p = 0; p < `NUM_PORTS; p++)
  begin : gLink
    assign req[p]            = links[p].req;
    assign timesUp[p]        = links[p].timesUp;
    assign flitValid[p]      = links[p].flitValid;
    assign flit[p]           = links[p].flit;
    assign links[p].runTimer = runTimer[p];
  end

  // Current owner from the one-hot state
  always_comb
  begin
    owner = '0;
    for (int i = 0; i < `NUM_PORTS; i++)
      if (grantState[i + 1])
        owner = portIdx'(i);
  end

  // ====================
  // Grant FSM
  // ====================

  always_comb
  begin
    int   cand;
    logic found;
    cand      = 0;
    found     = 1'b0;
    nextState = '0;
    runTimer  = '0;
    if (grantState[0])
    begin
      // From idle the lowest index wins
      for (int i = 0; i < `NUM_PORTS; i++)
        if (!found && req[i])
        begin
          nextState[i + 1] = 1'b1;
          found = 1'b1;
        end
    end
    else if (req[owner] && !timesUp[owner])
    begin
      runTimer[owner] = 1'b1;
      nextState       = grantState;
      found           = 1'b1;
    end
    else
    begin
      // Rotate from the port after the owner
      for (int k = 1; k < `NUM_PORTS; k++)
      begin
        cand = int'(owner) + k;
        if (cand >= `NUM_PORTS)
          cand = cand - `NUM_PORTS;
        if (!found && req[cand])
        begin
          nextState[cand + 1] = 1'b1;
          found = 1'b1;
        end
      end
    end
    if (!found)
      nextState[0] = 1'b1;  // Nobody asks
  end

  always_ff @(posedge clk)
  begin
    if (rst)
      grantState <= {{`NUM_PORTS{1'b0}}, 1'b1};
    else
      grantState <= nextState;
  end

  // ====================
  // Output stage
  // ====================

  always_ff @(posedge clk)
  begin
    if (rst)
      outValid <= 1'b0;
    else
      outValid <= !grantState[0] && flitValid[owner];
  end

  always_ff @(posedge clk)
  begin
    if (!grantState[0] && flitValid[owner])
      outFlit <= flit[owner];  // Flits of other ports are dropped
  end

  assert property (@(posedge clk) disable iff (rst) $onehot(grantState))
    else $error("grant state not one-hot");

  // Only the owner may run its timer
  assert property (@(posedge clk) disable iff (rst) $onehot0(runTimer))
    else $error("more than one hold timer running");

endmodule

//--- verilog/routerArbTop.sv
`include "routerArb_config.svh"

module routerArbTop (
  input  logic                               clk,
  input  logic                               rst,
  input  logic [`NUM_PORTS-1:0]              inValid,
  input  logic [`NUM_PORTS-1:0][`FLIT_W-1:0] inFlit,
  output logic [`NUM_PORTS:0]                grantState,
  output logic                               outValid,
  output logic [`FLIT_W-1:0]                 outFlit
);
  import routerArbPkg::*;

  logic [`NUM_PORTS-1:0]             decValid;
  flitWord [`NUM_PORTS-1:0]          decFlit;
  flitKind [`NUM_PORTS-1:0]          decKind;
  logic [`NUM_PORTS-1:0][`LEN_W-1:0] decLen;

  portLink link [`NUM_PORTS] ();

  flitDecoder uDecoder (
    .clk      (clk),
    .rst      (rst),
    .inValid  (inValid),
    .inFlit   (inFlit),
    .decValid (decValid),
    .decFlit  (decFlit),
    .decKind  (decKind),
    .decLen   (decLen)
  );

  // One port unit per input
  for (genvar i = 0; i < `NUM_PORTS; i++)
  begin : gPort
    localparam portIdx portNum = portIdx'(i);

    portTimer uTimer (
      .clk      (clk),
      .rst      (rst),
      .decValid (decValid[portNum]),
      .decFlit  (decFlit[portNum]),
      .decKind  (decKind[portNum]),
      .decLen   (decLen[portNum]),
      .link     (link[i])
    );
  end

  switchArbiter uArbiter (
    .clk        (clk),
    .rst        (rst),
    .links      (link),
    .grantState (grantState),
    .outValid   (outValid),
    .outFlit    (outFlit)
  );

endmodule

//--- verification/routerArbChecker.sv
`include "routerArb_config.svh"

module routerArbChecker (
  input  logic                clk,
  input  logic                checkEn,
  input  logic [`NUM_PORTS:0] expGrant,
  input  logic                expOutValid,
  input  logic [`FLIT_W-1:0]  expOutFlit,
  input  logic [`NUM_PORTS:0] grantState,
  input  logic                outValid,
  input  logic [`FLIT_W-1:0]  outFlit,
  output int                  errorCount,
  output int                  checkCount
);

  int errors = 0;
  int checks = 0;

  assign errorCount = errors;
  assign checkCount = checks;

  // Port name of a one-hot grant word
  function automatic string grantName(input logic [`NUM_PORTS:0] g);
    case (g)
      6'b000001: return "idle";
      6'b000010: return "Local";
      6'b000100: return "North";
      6'b001000: return "East";
      6'b010000: return "West";
      6'b100000: return "South";
      default:   return "not one-hot";
    endcase
  endfunction

  // ====================
  // Compare
  // ====================

  // Outputs settle after the rising edge, so sample in mid cycle
  always @(negedge clk)
  begin
    if (checkEn)
    begin
      checks++;
      if (grantState !== expGrant)
      begin
        $display("error %0t: grant is %s (%h), expected %s (%h)", $time,
                 grantName(grantState), grantState, grantName(expGrant), expGrant);
        errors++;
      end
      if (outValid !== expOutValid)
      begin
        $display("error %0t: outValid is %b, expected %b", $time, outValid, expOutValid);
        errors++;
      end
      else if (expOutValid && outFlit !== expOutFlit)
      begin
        $display("error %0t: outFlit is %h, expected %h", $time, outFlit, expOutFlit);
        errors++;
      end
    end
  end

endmodule

//--- verification/routerArbTb.sv
`include "routerArb_config.svh"

module routerArbTb;

  localparam int WordsPerVec = 9;  // valid, five flits, grant, outValid, outFlit
  localparam int MaxVecs     = 64;
  localparam int ClkPeriod   = 8;
  localparam int ResetCycles = 3;

  logic                               clk;
  logic                               rst;
  logic [`NUM_PORTS-1:0]              inValid;
  logic [`NUM_PORTS-1:0][`FLIT_W-1:0] inFlit;
  logic [`NUM_PORTS:0]                grantState;
  logic                               outValid;
  logic [`FLIT_W-1:0]                 outFlit;

  logic [`NUM_PORTS:0] expGrant;
  logic                expOutValid;
  logic [`FLIT_W-1:0]  expOutFlit;
  logic                checkEn;
  int                  errorCount;
  int                  checkCount;
  int                  setupErrors;

  logic [15:0] vecMem [MaxVecs*WordsPerVec];
  int          numVecs;
  logic        vecsLoaded;

  routerArbTop dut (
    .clk        (clk),
    .rst        (rst),
    .inValid    (inValid),
    .inFlit     (inFlit),
    .grantState (grantState),
    .outValid   (outValid),
    .outFlit    (outFlit)
  );

  routerArbChecker uChecker (
    .clk         (clk),
    .checkEn     (checkEn),
    .expGrant    (expGrant),
    .expOutValid (expOutValid),
    .expOutFlit  (expOutFlit),
    .grantState  (grantState),
    .outValid    (outValid),
    .outFlit     (outFlit),
    .errorCount  (errorCount),
    .checkCount  (checkCount)
  );

  initial
  begin
    clk = 1'b0;
    forever #(ClkPeriod / 2) clk = ~clk;
  end

  // ====================
  // Vector handling
  // ====================

  task automatic loadVectors();
    for (int i = 0; i < MaxVecs * WordsPerVec; i++)
      vecMem[i] = 16'hF000 | 16'(i);  // Words past the file keep a mark above 5 bits
    $readmemh("verification/routerArbVectors.txt", vecMem);
    numVecs = 0;
    while (numVecs < MaxVecs && vecMem[numVecs * WordsPerVec] <= 16'h001F)
      numVecs++;
  endtask

  task automatic applyVector(input int t);
    int base;
    base = t * WordsPerVec;
    inValid = vecMem[base][`NUM_PORTS-1:0];
    for (int p = 0; p < `NUM_PORTS; p++)
      inFlit[p] = vecMem[base + 1 + p];
    expGrant    = vecMem[base + 6][`NUM_PORTS:0];
    expOutValid = vecMem[base + 7][0];
    expOutFlit  = vecMem[base + 8];
  endtask

  // ====================
  // Stimulus
  // ====================

  initial
  begin
    rst         = 1'b1;
    inValid     = '0;
    inFlit      = '0;
    expGrant    = {{`NUM_PORTS{1'b0}}, 1'b1};
    expOutValid = 1'b0;
    expOutFlit  = '0;
    checkEn     = 1'b0;
    setupErrors = 0;
    vecsLoaded  = 1'b0;
    loadVectors();
    if (numVecs == 0)
    begin
      $display("no test vectors could be read from verification/routerArbVectors.txt");
      setupErrors++;
    end
    vecsLoaded = 1'b1;
    repeat (ResetCycles) @(posedge clk);
    for (int t = 0; t < numVecs; t++)
    begin
      if (t > 0)
        @(posedge clk);
      #1;
      rst = 1'b0;
      applyVector(t);
      checkEn = 1'b1;  // Checked on the falling edge of this cycle
    end
    @(posedge clk);
    #1 checkEn = 1'b0;
    $display("checks: %0d, errors: %0d, setup errors: %0d", checkCount, errorCount,
             setupErrors);
    if (errorCount == 0 && setupErrors == 0 && checkCount == numVecs)
      $display("Result: PASSED");
    else
      $display("Result: FAILED");
    $finish;
  end

  // Watchdog
  initial
  begin
    wait (vecsLoaded);
    #((numVecs + 20) * ClkPeriod);
    $display("timeout: the run did not finish within %0d clock cycles", numVecs + 20);
    $display("Result: FAILED");
    $finish;
  end

endmodule

//--- verification/routerArbVectors.txt
// valid L N E W S grant outValid outFlit, one line per clock cycle
// valid bit 0 is Local, then North, East, West, South; grant bit 0 is idle
// North packet, West body flits are dropped
00 0000 0000 0000 0000 0000 01 0 0000
00 0000 0000 0000 0000 0000 01 0 0000
02 0000 200A 0000 0000 0000 01 0 0000
0A 0000 4011 0000 4ABC 0000 01 0 0000
0A 0000 4022 0000 4DEF 0000 04 0 0000
02 0000 6033 0000 0000 0000 04 1 4011
00 0000 0000 0000 0000 0000 04 1 4022
00 0000 0000 0000 0000 0000 04 1 6033
// Local, West and South start together, length 1 each
19 2001 0000 0000 2001 2001 01 0 0000
19 4101 0000 0000 4301 4401 01 0 0000
19 4102 0000 0000 4302 4402 02 0 0000
19 4103 0000 0000 4303 4403 02 1 4101
19 4104 0000 0000 4304 4404 10 1 4102
19 4105 0000 0000 6305 4405 10 1 4303
11 4106 0000 0000 0000 4406 20 1 4304
11 4107 0000 0000 0000 6407 20 1 4405
01 6108 0000 0000 0000 0000 02 1 4406
00 0000 0000 0000 0000 0000 02 1 4107
00 0000 0000 0000 0000 0000 01 1 6108
// East alone, length 2, times out and is granted again
04 0000 0000 2002 0000 0000 01 0 0000
04 0000 0000 4201 0000 0000 01 0 0000
04 0000 0000 4202 0000 0000 08 0 0000
04 0000 0000 4203 0000 0000 08 1 4201
04 0000 0000 4204 0000 0000 08 1 4202
04 0000 0000 4205 0000 0000 01 1 4203
04 0000 0000 4206 0000 0000 08 0 0000
04 0000 0000 6207 0000 0000 08 1 4205
00 0000 0000 0000 0000 0000 08 1 4206
00 0000 0000 0000 0000 0000 01 1 6207
00 0000 0000 0000 0000 0000 01 0 0000
00 0000 0000 0000 0000 0000 01 0 0000

//--- src.f
+incdir+include
verilog/routerArbPkg.sv
verilog/portLink.sv
verilog/flitDecoder.sv
verilog/portTimer.sv
verilog/switchArbiter.sv
verilog/routerArbTop.sv
verification/routerArbChecker.sv
verification/routerArbTb.sv

//--- run.sh
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
  --top-module routerArbTb -f src.f --Mdir obj_dir -o simv

./obj_dir/simv | tee sim.log

if grep -qx "Result: PASSED" sim.log
then
  echo "simulation passed"
else
  echo "simulation failed, see sim.log"
  exit 1
fi
